/* tamagotchi_top.f */
pet_cfg_pkg.sv
pet_types_pkg.sv
button_conditioner.sv
long_press_timer.sv
need_decay.sv
pet_fsm.sv
tamagotchi_top.sv
pet_monitor.sv
tamagotchi_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pet controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tamagotchi_tb \
    -f tamagotchi_top.f -o tamagotchi_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tamagotchi_sim > sim.log 2>&1
cat sim.log

grep -qx "Simulation PASSED" sim.log && echo "Run result: pass" \
    || { echo "Run result: fail"; exit 1; }

/* tamagotchi_tb.sv */
module tamagotchi_tb;

    localparam int         NUM_ENTRIES  = 18;
    localparam int         RESET_CYCLES = 4;
    localparam int         EXTRA_MAX    = 7;    // Largest random idle extension
    localparam int         MARGIN       = 200;  // Watchdog slack in cycles
    localparam int         ANY_LEVEL    = 15;   // Level left to the reference model
    localparam logic [2:0] B_RESET      = 3'd4; // Codes 0..3 are the need buttons
    localparam logic [2:0] B_TEST       = 3'd5;
    localparam logic [2:0] B_NONE       = 3'd6;

    typedef struct packed {
        logic [2:0]           code;   // Button held
        int                   hold;   // Cycles held
        int                   idle;   // Cycles released before the check
        pet_types_pkg::need_e need;   // Expected selection
        logic                 mode;   // Expected test mode
        int                   level;  // Expected level or ANY_LEVEL
    } entry_t;

    logic                              clk = 1'b0;
    logic                              arst_n;
    logic [pet_cfg_pkg::NUM_NEEDS-1:0] btn_need;
    logic                              btn_reset;
    logic                              btn_test;
    pet_types_pkg::need_e              display_need;
    logic [pet_cfg_pkg::LEVEL_W-1:0]   display_level;
    pet_types_pkg::face_e              face;
    logic                              test_mode;
    logic                              check_req;   // One cycle per entry
    int                                test_id;
    pet_types_pkg::need_e              exp_need;
    logic                              exp_mode;
    int                                exp_level;
    int                                pass_count;
    int                                fail_count;
    int                                seed = 40;

    entry_t stim [NUM_ENTRIES] = '{
        '{B_NONE,   0,   4, pet_types_pkg::NEED_HEALTH, 1'b0, 10},         // State after reset
        '{3'd1,     8,  12, pet_types_pkg::NEED_ENERGY, 1'b0, 10},         // Select energy
        '{3'd1,     8,  12, pet_types_pkg::NEED_ENERGY, 1'b0, 10},         // Feed at full
        '{3'd2,     3,  12, pet_types_pkg::NEED_ENERGY, 1'b0, 10},         // Short hunger bounce
        '{B_NONE,   0, 400, pet_types_pkg::NEED_ENERGY, 1'b0, ANY_LEVEL},  // Energy decays
        '{3'd1,     8,  12, pet_types_pkg::NEED_ENERGY, 1'b0, ANY_LEVEL},  // Feed one up
        '{3'd3,     8,  12, pet_types_pkg::NEED_FUN,    1'b0, ANY_LEVEL},  // Select fun
        '{B_NONE,   0, 900, pet_types_pkg::NEED_FUN,    1'b0, 0},          // Empty and sad
        '{3'd3,     8,  12, pet_types_pkg::NEED_FUN,    1'b0, ANY_LEVEL},  // Feed from empty
        '{B_TEST, 100,  12, pet_types_pkg::NEED_FUN,    1'b1, ANY_LEVEL},  // Enter test mode
        '{3'd3,     8,  12, pet_types_pkg::NEED_FUN,    1'b1, 10},         // Toggle up
        '{3'd3,     8,  12, pet_types_pkg::NEED_FUN,    1'b1, 1},          // Toggle down
        '{B_NONE,   0, 300, pet_types_pkg::NEED_FUN,    1'b1, 1},          // No decay
        '{3'd2,     8,  12, pet_types_pkg::NEED_HUNGER, 1'b1, ANY_LEVEL},  // Select hunger
        '{B_RESET, 40,  12, pet_types_pkg::NEED_HUNGER, 1'b1, ANY_LEVEL},  // Short reset hold
        '{B_RESET, 100, 12, pet_types_pkg::NEED_HEALTH, 1'b0, 10},         // Long reset
        '{B_TEST,  40,  12, pet_types_pkg::NEED_HEALTH, 1'b0, 10},         // Short test hold
        '{B_NONE,   0,  20, pet_types_pkg::NEED_HEALTH, 1'b0, 10}          // Settled
    };

    always #2 clk = ~clk;                            // Period 4

    tamagotchi_top dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .btn_need      (btn_need),
        .btn_reset     (btn_reset),
        .btn_test      (btn_test),
        .display_need  (display_need),
        .display_level (display_level),
        .face          (face),
        .test_mode     (test_mode)
    );

    pet_monitor checker_inst (
        .clk (clk), .arst_n (arst_n),
        .btn_need (btn_need), .btn_reset (btn_reset), .btn_test (btn_test),
        .display_need (display_need), .display_level (display_level),
        .face (face), .test_mode (test_mode),
        .check_req (check_req), .test_id (test_id),
        .exp_need (exp_need), .exp_mode (exp_mode), .exp_level (exp_level),
        .pass_count (pass_count), .fail_count (fail_count)
    );

    task automatic drive_buttons(input logic [2:0] code);
        btn_need  = '0;
        btn_reset = (code == B_RESET);
        btn_test  = (code == B_TEST);
        if (code < 3'd4) begin
            btn_need[code[1:0]] = 1'b1;
        end
    endtask

    // Starts and ends one cycle unit after a rising edge
    task automatic apply_entry(input int k);
        int gap;
        gap = stim[k].idle + ($random(seed) & EXTRA_MAX);
        if (stim[k].hold > 0) begin
            drive_buttons(stim[k].code);
            repeat (stim[k].hold) @(posedge clk);
            #1;
            drive_buttons(B_NONE);
        end
        repeat (gap) @(posedge clk);
        #1;
        test_id   = k;
        exp_need  = stim[k].need;
        exp_mode  = stim[k].mode;
        exp_level = stim[k].level;
        check_req = 1'b1;                            // Sampled on the next falling edge
        @(posedge clk);
        #1;
        check_req = 1'b0;
    endtask

    initial begin
        arst_n    = 1'b0;
        btn_need  = '0;
        btn_reset = 1'b0;
        btn_test  = 1'b0;
        check_req = 1'b0;
        test_id   = 0;
        exp_need  = pet_types_pkg::NEED_HEALTH;
        exp_mode  = 1'b0;
        exp_level = ANY_LEVEL;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            apply_entry(k);
        end
        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count == NUM_ENTRIES) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Run length from the table plus worst-case random gaps
    initial begin
        int limit;
        #1;
        limit = RESET_CYCLES + MARGIN;
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            limit += stim[k].hold + stim[k].idle + EXTRA_MAX + 1;
        end
        #(limit * 4);
        $display("Timeout: the tests did not finish within %0d cycles", limit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* pet_monitor.sv */
module pet_monitor (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [pet_cfg_pkg::NUM_NEEDS-1:0] btn_need,
    input  logic                              btn_reset,
    input  logic                              btn_test,
    input  pet_types_pkg::need_e              display_need,
    input  logic [pet_cfg_pkg::LEVEL_W-1:0]   display_level,
    input  pet_types_pkg::face_e              face,
    input  logic                              test_mode,
    input  logic                              check_req,
    input  int                                test_id,
    input  pet_types_pkg::need_e              exp_need,
    input  logic                              exp_mode,
    input  int                                exp_level,
    output int                                pass_count,
    output int                                fail_count
);

    localparam int HIST      = pet_cfg_pkg::DEBOUNCE_CYCLES + 2;  // Two sync stages plus window
    localparam int ANY_LEVEL = 15;                                // Table leaves level open

    logic [5:0] hist [HIST];     // Raw samples, newest at index 0
    logic [5:0] deb;             // Accepted button levels
    int         pend;            // Press for the FSM next edge, -1 none
    int         edge_cnt;        // Rising edges since reset release
    int         hold [2];        // Ticks held, reset then test
    int         dcnt [pet_cfg_pkg::NUM_NEEDS];
    int         lv   [pet_cfg_pkg::NUM_NEEDS];
    int         sel;
    logic       mode;            // Expected test mode
    logic       test_bad;

    // Decay period of each need in ticks
    function automatic int decay_period(input int idx);
        case (idx)
            0:       return pet_cfg_pkg::DECAY_HEALTH;
            1:       return pet_cfg_pkg::DECAY_ENERGY;
            2:       return pet_cfg_pkg::DECAY_HUNGER;
            default: return pet_cfg_pkg::DECAY_FUN;
        endcase
    endfunction

    task automatic compare_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            test_bad = 1'b1;
            $display("CHECK FAILED t=%0t %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    // Reference model, one step per rising edge
    always @(posedge clk or negedge arst_n) begin
        logic                              tick;
        logic [1:0]                        fire;
        logic [pet_cfg_pkg::NUM_NEEDS-1:0] dp;
        logic [5:0]                        flip;
        int                                nsel;
        logic                              fed;
        if (!arst_n) begin
            for (int k = 0; k < HIST; k++) begin
                hist[k] = '0;
            end
            deb      = '0;
            pend     = -1;
            edge_cnt = 0;
            hold[0]  = 0;
            hold[1]  = 0;
            for (int i = 0; i < pet_cfg_pkg::NUM_NEEDS; i++) begin
                dcnt[i] = 0;
                lv[i]   = pet_cfg_pkg::LEVEL_MAX;
            end
            sel  = 0;                                   // Health
            mode = 1'b0;
        end else begin
            edge_cnt++;
            tick = (edge_cnt % pet_cfg_pkg::TICK_CYCLES == 0);  // First on edge 16
            fire = '0;
            for (int b = 0; b < 2; b++) begin
                if (!deb[4+b]) begin
                    hold[b] = 0;                        // Released
                end else if (tick && hold[b] < pet_cfg_pkg::LONG_PRESS_TICKS) begin
                    hold[b]++;
                    fire[b] = (hold[b] == pet_cfg_pkg::LONG_PRESS_TICKS);  // Once per hold
                end
            end
            for (int i = 0; i < pet_cfg_pkg::NUM_NEEDS; i++) begin
                dp[i] = 1'b0;
                if (mode) begin
                    dcnt[i] = 0;                        // Frozen in test mode
                end else if (tick) begin
                    dcnt[i]++;
                    if (dcnt[i] == decay_period(i)) begin
                        dp[i]   = 1'b1;
                        dcnt[i] = 0;
                    end
                end
            end
            if (fire[0]) begin                          // Long reset first
                for (int i = 0; i < pet_cfg_pkg::NUM_NEEDS; i++) begin
                    lv[i] = pet_cfg_pkg::LEVEL_MAX;
                end
                sel  = 0;
                mode = 1'b0;
            end else if (fire[1]) begin
                mode = 1'b1;                            // Press in this cycle is lost
            end else begin
                nsel = (pend >= 0 && pend != sel) ? pend : sel;
                for (int i = 0; i < pet_cfg_pkg::NUM_NEEDS; i++) begin
                    fed = (pend == i) && (sel == i);
                    if (mode) begin
                        if (fed) begin
                            lv[i] = (lv[i] == pet_cfg_pkg::LEVEL_MAX) ?
                                    pet_cfg_pkg::LEVEL_MIN_TEST : pet_cfg_pkg::LEVEL_MAX;
                        end
                    end else if (fed && !dp[i]) begin
                        lv[i] = (lv[i] < pet_cfg_pkg::LEVEL_MAX) ? lv[i] + 1 : lv[i];
                    end else if (dp[i] && !fed) begin
                        lv[i] = (lv[i] > 0) ? lv[i] - 1 : 0;
                    end
                end
                sel = nsel;
            end
            // Accept a value seen on five straight synchronized samples
            for (int b = 0; b < 6; b++) begin
                flip[b] = 1'b1;
                for (int k = 1; k < HIST; k++) begin
                    if (hist[k][b] == deb[b]) begin
                        flip[b] = 1'b0;
                    end
                end
            end
            deb  = deb ^ flip;
            pend = -1;
            for (int i = pet_cfg_pkg::NUM_NEEDS - 1; i >= 0; i--) begin
                if (flip[i] && deb[i]) begin
                    pend = i;                           // Lowest index kept
                end
            end
            for (int k = HIST - 1; k > 0; k--) begin
                hist[k] = hist[k-1];
            end
            hist[0] = {btn_test, btn_reset, btn_need};
        end
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (!arst_n) begin
            pass_count = 0;
            fail_count = 0;
        end else if (check_req) begin
            test_bad = 1'b0;
            compare_value("display_need", sel, int'(display_need));
            compare_value("display_level", lv[sel], int'(display_level));
            compare_value("face", (lv[sel] >= pet_cfg_pkg::HAPPY_THRESHOLD) ?
                          int'(pet_types_pkg::FACE_HAPPY) : int'(pet_types_pkg::FACE_SAD),
                          int'(face));
            compare_value("test_mode", int'(mode), int'(test_mode));
            compare_value("display_need (table)", int'(exp_need), int'(display_need));
            compare_value("test_mode (table)", int'(exp_mode), int'(test_mode));
            if (exp_level != ANY_LEVEL) begin
                compare_value("display_level (table)", exp_level, int'(display_level));
            end
            if (test_bad) begin
                fail_count++;
                $display("Test %0d failed at t=%0t", test_id, $time);
            end else begin
                pass_count++;
                $display("Test %0d passed, need %0d level %0d mode %0d",
                         test_id, int'(display_need), int'(display_level), test_mode);
            end
        end
    end

endmodule

/* tamagotchi_top.sv */
module tamagotchi_top (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [pet_cfg_pkg::NUM_NEEDS-1:0] btn_need,
    input  logic                              btn_reset,
    input  logic                              btn_test,
    output pet_types_pkg::need_e              display_need,
    output logic [pet_cfg_pkg::LEVEL_W-1:0]   display_level,
    output pet_types_pkg::face_e              face,
    output logic                              test_mode
);

    logic [pet_cfg_pkg::NUM_NEEDS-1:0] need_pulse;   // One-cycle accepted presses
    logic [pet_cfg_pkg::NUM_NEEDS-1:0] decay_pulse;  // One-cycle decrement requests
    logic                              reset_held;   // Debounced reset button
    logic                              test_held;    // Debounced test button
    logic                              tick;         // One per second
    logic                              reset_cmd;
    logic                              test_cmd;
    logic                              freeze;       // Test mode, stops decay

    button_conditioner u_buttons (
        .clk        (clk),
        .arst_n     (arst_n),
        .btn_need   (btn_need),
        .btn_reset  (btn_reset),
        .btn_test   (btn_test),
        .need_pulse (need_pulse),
        .reset_held (reset_held),
        .test_held  (test_held)
    );

    long_press_timer u_timer (
        .clk        (clk),
        .arst_n     (arst_n),
        .reset_held (reset_held),
        .test_held  (test_held),
        .tick       (tick),
        .reset_cmd  (reset_cmd),
        .test_cmd   (test_cmd)
    );

    need_decay u_decay (
        .clk         (clk),
        .arst_n      (arst_n),
        .tick        (tick),
        .freeze      (freeze),
        .decay_pulse (decay_pulse)
    );

    pet_fsm u_fsm (
        .clk           (clk),
        .arst_n        (arst_n),
        .need_pulse    (need_pulse),
        .decay_pulse   (decay_pulse),
        .reset_cmd     (reset_cmd),
        .test_cmd      (test_cmd),
        .freeze        (freeze),
        .display_need  (display_need),
        .display_level (display_level),
        .face          (face),
        .test_mode     (test_mode)
    );

endmodule

/* pet_fsm.sv */
module pet_fsm (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [pet_cfg_pkg::NUM_NEEDS-1:0] need_pulse,
    input  logic [pet_cfg_pkg::NUM_NEEDS-1:0] decay_pulse,
    input  logic                              reset_cmd,
    input  logic                              test_cmd,
    output logic                              freeze,
    output pet_types_pkg::need_e              display_need,
    output logic [pet_cfg_pkg::LEVEL_W-1:0]   display_level,
    output pet_types_pkg::face_e              face,
    output logic                              test_mode
);

    typedef logic [pet_cfg_pkg::LEVEL_W-1:0]   level_t;
    typedef logic [pet_cfg_pkg::NUM_NEEDS-1:0] need_vec_t;

    level_t               lvl     [pet_cfg_pkg::NUM_NEEDS];  // Current levels
    level_t               lvl_nxt [pet_cfg_pkg::NUM_NEEDS];
    pet_types_pkg::need_e sel;            // Need on the display
    pet_types_pkg::need_e sel_nxt;
    logic                 mode_nxt;
    need_vec_t            sel_hot;        // sel as a one-hot mask
    need_vec_t            feed;           // Press on the already selected need
    level_t               shown_nxt;      // Level the display will show

    assign sel_hot = need_vec_t'(1) << sel;
    assign feed    = need_pulse & sel_hot;

    always_comb begin
        lvl_nxt  = lvl;
        sel_nxt  = sel;
        mode_nxt = test_mode;
        if (reset_cmd) begin                      // Long reset beats everything
            for (int i = 0; i < pet_cfg_pkg::NUM_NEEDS; i++) begin
                lvl_nxt[i] = level_t'(pet_cfg_pkg::LEVEL_MAX);
            end
            sel_nxt  = pet_types_pkg::NEED_HEALTH;
            mode_nxt = 1'b0;
        end else if (test_cmd) begin              // Entry cycle, presses and decay dropped
            mode_nxt = 1'b1;
        end else begin
            for (int i = 0; i < pet_cfg_pkg::NUM_NEEDS; i++) begin
                if (need_pulse[i] && !feed[i]) begin
                    sel_nxt = pet_types_pkg::need_e'(i);  // First press only selects
                end
                if (test_mode) begin
                    if (feed[i]) begin
                        lvl_nxt[i] = (lvl[i] == level_t'(pet_cfg_pkg::LEVEL_MAX)) ?
                                     level_t'(pet_cfg_pkg::LEVEL_MIN_TEST) :
                                     level_t'(pet_cfg_pkg::LEVEL_MAX);
                    end
                end else if (feed[i] && !decay_pulse[i]) begin
                    if (lvl[i] != level_t'(pet_cfg_pkg::LEVEL_MAX)) begin
                        lvl_nxt[i] = lvl[i] + 1'b1;        // Feed, stops at full
                    end
                end else if (decay_pulse[i] && !feed[i]) begin
                    if (lvl[i] != '0) begin
                        lvl_nxt[i] = lvl[i] - 1'b1;        // Decay, stops at empty
                    end
                end
            end
        end
    end

    assign shown_nxt = lvl_nxt[sel_nxt];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < pet_cfg_pkg::NUM_NEEDS; i++) begin
                lvl[i] <= level_t'(pet_cfg_pkg::LEVEL_MAX);
            end
            sel           <= pet_types_pkg::NEED_HEALTH;
            test_mode     <= 1'b0;
            display_level <= level_t'(pet_cfg_pkg::LEVEL_MAX);
            face          <= pet_types_pkg::FACE_HAPPY;
        end else begin
            lvl           <= lvl_nxt;
            sel           <= sel_nxt;
            test_mode     <= mode_nxt;
            display_level <= shown_nxt;           // Same edge as the level change
            face          <= (shown_nxt >= level_t'(pet_cfg_pkg::HAPPY_THRESHOLD)) ?
                             pet_types_pkg::FACE_HAPPY : pet_types_pkg::FACE_SAD;
        end
    end

    assign display_need = sel;
    assign freeze       = test_mode;              // Decay counters idle in test mode

    for (genvar g = 0; g < pet_cfg_pkg::NUM_NEEDS; g++) begin : g_lvl_chk
        a_level_max: assert property (@(posedge clk) disable iff (!arst_n)
            lvl[g] <= level_t'(pet_cfg_pkg::LEVEL_MAX))
            else $error("level %0d above maximum", g);
    end

endmodule

/* need_decay.sv */
module need_decay (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              tick,
    input  logic                              freeze,
    output logic [pet_cfg_pkg::NUM_NEEDS-1:0] decay_pulse
);

    typedef logic [pet_cfg_pkg::DECAY_W-1:0] decay_cnt_t;

    decay_cnt_t cnt [pet_cfg_pkg::NUM_NEEDS];  // Ticks since last decay

    // Count value on the tick that ends a period
    function automatic decay_cnt_t last_count(input int idx);
        case (pet_types_pkg::need_e'(idx))
            pet_types_pkg::NEED_HEALTH: return decay_cnt_t'(pet_cfg_pkg::DECAY_HEALTH - 1);
            pet_types_pkg::NEED_ENERGY: return decay_cnt_t'(pet_cfg_pkg::DECAY_ENERGY - 1);
            pet_types_pkg::NEED_HUNGER: return decay_cnt_t'(pet_cfg_pkg::DECAY_HUNGER - 1);
            default:                    return decay_cnt_t'(pet_cfg_pkg::DECAY_FUN - 1);
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < pet_cfg_pkg::NUM_NEEDS; i++) begin
            decay_pulse[i] = tick && !freeze && (cnt[i] == last_count(i));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < pet_cfg_pkg::NUM_NEEDS; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < pet_cfg_pkg::NUM_NEEDS; i++) begin
                if (freeze) begin
                    cnt[i] <= '0;              // Test mode holds all periods
                end else if (tick) begin
                    if (decay_pulse[i]) begin
                        cnt[i] <= '0;          // Period done, restart
                    end else begin
                        cnt[i] <= cnt[i] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* long_press_timer.sv */
module long_press_timer (
    input  logic clk,
    input  logic arst_n,
    input  logic reset_held,
    input  logic test_held,
    output logic tick,
    output logic reset_cmd,
    output logic test_cmd
);

    typedef logic [pet_cfg_pkg::TICK_W-1:0] tick_cnt_t;
    typedef logic [pet_cfg_pkg::HOLD_W-1:0] hold_cnt_t;

    tick_cnt_t presc;              // Cycles into the current second
    hold_cnt_t hold_cnt [2];       // Index 0 reset, 1 test
    logic [1:0] held;
    logic [1:0] fire;

    assign held = {test_held, reset_held};

    // Last cycle of each second
    assign tick = (presc == tick_cnt_t'(pet_cfg_pkg::TICK_CYCLES - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            presc <= '0;
        end else if (tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            fire[i] = held[i] && tick &&
                      (hold_cnt[i] == hold_cnt_t'(pet_cfg_pkg::LONG_PRESS_TICKS - 1));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hold_cnt[0] <= '0;
            hold_cnt[1] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (!held[i]) begin
                    hold_cnt[i] <= '0;     // Released, next hold starts fresh
                end else if (tick &&
                             hold_cnt[i] != hold_cnt_t'(pet_cfg_pkg::LONG_PRESS_TICKS)) begin
                    hold_cnt[i] <= hold_cnt[i] + 1'b1; // Saturates, fires once
                end
            end
        end
    end

    assign reset_cmd = fire[0];
    assign test_cmd  = fire[1];

    // Decay and hold counters rely on single-cycle ticks
    a_tick_single: assert property (@(posedge clk) disable iff (!arst_n)
        tick |=> !tick)
        else $error("tick high in consecutive cycles");

endmodule

/* button_conditioner.sv */
module button_conditioner (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [pet_cfg_pkg::NUM_NEEDS-1:0] btn_need,
    input  logic                              btn_reset,
    input  logic                              btn_test,
    output logic [pet_cfg_pkg::NUM_NEEDS-1:0] need_pulse,
    output logic                              reset_held,
    output logic                              test_held
);

    typedef logic [pet_cfg_pkg::DEBOUNCE_W-1:0] deb_cnt_t;
    typedef logic [pet_cfg_pkg::NUM_NEEDS-1:0]  need_vec_t;

    logic [5:0] raw;               // Test, reset, then the need buttons
    logic [5:0] sync_q1;           // First synchronizer stage
    logic [5:0] sync_q2;           // Second stage, safe to use
    logic [5:0] stable;            // Debounced levels
    logic [5:0] accept;            // Stable long enough, flip this cycle
    deb_cnt_t   cnt [6];           // Cycles the new value has held
    need_vec_t  rise;              // Accepted need presses, may be several
    need_vec_t  pulse_q;

    assign raw = {btn_test, btn_reset, btn_need};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= raw;        // Asynchronous inputs land here
            sync_q2 <= sync_q1;
        end
    end

    always_comb begin
        for (int i = 0; i < 6; i++) begin
            accept[i] = (sync_q2[i] != stable[i]) &&
                        (cnt[i] == deb_cnt_t'(pet_cfg_pkg::DEBOUNCE_CYCLES));
        end
    end

    // Only press edges of the need buttons matter
    assign rise = accept[pet_cfg_pkg::NUM_NEEDS-1:0] & sync_q2[pet_cfg_pkg::NUM_NEEDS-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stable  <= '0;
            pulse_q <= '0;
            for (int i = 0; i < 6; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 6; i++) begin
                if (sync_q2[i] == stable[i] || accept[i]) begin
                    cnt[i] <= '0;          // Bounce or done, start over
                end else begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
            stable  <= stable ^ accept;    // Take the new value
            pulse_q <= rise & (~rise + 1'b1); // Lowest index wins
        end
    end

    assign need_pulse = pulse_q;
    assign reset_held = stable[4];
    assign test_held  = stable[5];

    // FSM decodes need_pulse as a single selection
    a_pulse_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(need_pulse))
        else $error("need_pulse has more than one bit set");

endmodule

/* pet_types_pkg.sv */
package pet_types_pkg;

    // Need index, also the bit position in the need button vector
    typedef enum logic [1:0] {
        NEED_HEALTH = 2'd0,  // Selected after reset
        NEED_ENERGY = 2'd1,
        NEED_HUNGER = 2'd2,
        NEED_FUN    = 2'd3
    } need_e;

    // Face shown next to the selected level
    typedef enum logic {
        FACE_SAD   = 1'b0,   // Level below the threshold
        FACE_HAPPY = 1'b1    // Level at or above the threshold
    } face_e;

endpackage

/* pet_cfg_pkg.sv */
package pet_cfg_pkg;

    // Need set and level range
    localparam int NUM_NEEDS       = 4;   // Health, energy, hunger, fun
    localparam int LEVEL_W         = 4;   // Holds 0..10
    localparam int LEVEL_MAX       = 10;  // Full level, also reset value
    localparam int LEVEL_MIN_TEST  = 1;   // Low end of the test-mode toggle
    localparam int HAPPY_THRESHOLD = 5;   // Face is happy at or above this

    // Seconds prescaler, simulation scale
    localparam int TICK_CYCLES = 16;      // Board build sets the real clock rate here
    localparam int TICK_W      = $clog2(TICK_CYCLES);

    // Button conditioning
    localparam int DEBOUNCE_CYCLES = 4;   // Stable cycles after the synchronizer
    localparam int DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES + 1);

    // Long-press detection for reset and test
    localparam int LONG_PRESS_TICKS = 5;  // Five seconds of hold
    localparam int HOLD_W           = $clog2(LONG_PRESS_TICKS + 1);

    // Decay periods in ticks
    localparam int DECAY_HEALTH = 12;
    localparam int DECAY_ENERGY = 10;
    localparam int DECAY_HUNGER = 7;
    localparam int DECAY_FUN    = 5;      // Fastest need

    // Sized for the slowest period
    localparam int DECAY_W = $clog2(DECAY_HEALTH + 1);

endpackage
